// File: run_sim.sh
#!/bin/sh
# builds the status memory testbench with Verilator, runs it and
# decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_neuron_status_mem

verilator --binary --timing --timescale 1ns/100ps \
	--top-module "$TOP" -f tb.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# the vector file path is relative to the project root
./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -qx "NO ERRORS" "$LOG"
if [ $? -eq 0 ]; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// File: source/bank_if.sv
// ----------------------------------------
// read and write port pair of one memory
// bank. the bank takes the owner side, the
// control logic the user side
// ----------------------------------------

interface bank_if
#(
	parameter int ADDR_W = 4,
	parameter int WORD_W = 16
);

	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;

	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;

	modport owner
	(
		input rd_en, rd_addr, wr_en, wr_addr, wr_data,
		output rd_data
	);

	modport user
	(
		output rd_en, rd_addr, wr_en, wr_addr, wr_data,
		input rd_data
	);

endinterface

// File: source/neuron_geom_pkg.sv
// ----------------------------------------
// array sizes and word widths of the core's
// status memory. import where a width or
// address type is needed
// ----------------------------------------

package neuron_geom_pkg;

	// 16 neurons, 16 axons per neuron
	localparam int NEURON_ADDR_W = 4;
	localparam int AXON_ADDR_W = 4;
	// neuron index in the upper field, axon in the lower
	localparam int SYNAPSE_ADDR_W = NEURON_ADDR_W + AXON_ADDR_W;

	localparam int DATA_W = 16;
	localparam int HIST_W = 8;
	localparam int FIFO_ADDR_W = 5;

	// neuron index followed by the two field select bits
	localparam int STATE_RD_ADDR_W = NEURON_ADDR_W + 2;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [NEURON_ADDR_W-1:0] neuron_addr_t;
	typedef logic [SYNAPSE_ADDR_W-1:0] synapse_addr_t;

endpackage

// File: source/neuron_state_mem.sv
// ----------------------------------------
// the four per-neuron state banks behind one
// read port and one write port. the field is
// picked by the low read address bits
// ----------------------------------------

module neuron_state_mem
(
	input logic clk_i,
	input logic rst_n_i,

	input logic [neuron_geom_pkg::STATE_RD_ADDR_W-1:0] rd_addr_i,
	input logic [3:0] rd_en_i,
	input neuron_geom_pkg::neuron_addr_t wr_addr_i,
	input neuron_geom_pkg::data_t wr_data_i,
	input logic [3:0] wr_en_i,

	output neuron_geom_pkg::data_t rd_data_o
);

	import neuron_geom_pkg::*;
	import state_field_pkg::*;

	neuron_addr_t rd_neuron;
	state_field_e field_sel_q;
	data_t field_rd [4];

	assign rd_neuron = rd_addr_i[STATE_RD_ADDR_W-1:FIELD_SEL_W];

	// field select loads on every edge, not only with an enable
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			field_sel_q <= FIELD_BIAS;
		else
			field_sel_q <= state_field_e'(rd_addr_i[FIELD_SEL_W-1:0]);
	end

	// one bank per field, history bank is narrower
	for (genvar i = 0; i < 4; i++)
	begin : g_field
		bank_if
		#(
			.ADDR_W(NEURON_ADDR_W),
			.WORD_W((i == FIELD_POST_HISTORY) ? HIST_W : DATA_W)
		) field_bus ();

		assign field_bus.rd_en = rd_en_i[i];
		assign field_bus.rd_addr = rd_neuron;
		assign field_bus.wr_en = wr_en_i[i];
		assign field_bus.wr_addr = wr_addr_i;
		// history keeps only its low bits
		assign field_bus.wr_data = wr_data_i[$bits(field_bus.wr_data)-1:0];

		status_bank
		#(
			.ADDR_W(NEURON_ADDR_W),
			.WORD_W((i == FIELD_POST_HISTORY) ? HIST_W : DATA_W)
		) u_bank
		(
			.clk_i(clk_i),
			.mem(field_bus)
		);

		// zero-extend up to the port width
		assign field_rd[i] = data_t'(field_bus.rd_data);
	end

	always_comb
	begin
		case (field_sel_q)
			FIELD_BIAS: rd_data_o = field_rd[FIELD_BIAS];
			FIELD_POTENTIAL: rd_data_o = field_rd[FIELD_POTENTIAL];
			FIELD_THRESHOLD: rd_data_o = field_rd[FIELD_THRESHOLD];
			default: rd_data_o = field_rd[FIELD_POST_HISTORY];
		endcase
	end

endmodule

// File: source/neuron_status_mem.sv
// ----------------------------------------
// status memory of one core: neuron state,
// the synapse weight bank and the weight
// prefetch queue. start_i clears the queue
// ----------------------------------------

module neuron_status_mem
(
	input logic clk_i,
	input logic rst_n_i,
	input logic start_i,

	// port A, shared state read
	input logic [neuron_geom_pkg::STATE_RD_ADDR_W-1:0] state_rd_addr_i,
	input logic bias_rd_en_i,
	input logic potential_rd_en_i,
	input logic threshold_rd_en_i,
	input logic post_history_rd_en_i,
	output neuron_geom_pkg::data_t state_rd_data_o,

	// port B, shared state write
	input neuron_geom_pkg::neuron_addr_t state_wr_addr_i,
	input neuron_geom_pkg::data_t state_wr_data_i,
	input logic bias_wr_en_i,
	input logic potential_wr_en_i,
	input logic threshold_wr_en_i,
	input logic post_history_wr_en_i,

	// port E, weight read
	input neuron_geom_pkg::synapse_addr_t weight_rd_addr_i,
	input logic weight_rd_en_i,
	output neuron_geom_pkg::data_t weight_rd_data_o,

	// port G, weight write
	input neuron_geom_pkg::synapse_addr_t weight_wr_addr_i,
	input logic weight_wr_en_i,
	input neuron_geom_pkg::data_t weight_wr_data_i,

	// port F, queued weights
	input logic weight_pop_i,
	output neuron_geom_pkg::data_t weight_head_o,
	output logic weight_empty_o
);

	import neuron_geom_pkg::*;

	bank_if #(.ADDR_W(SYNAPSE_ADDR_W), .WORD_W(DATA_W)) weight_bus ();

	// enable bit order matches the field encoding
	neuron_state_mem u_state_mem
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rd_addr_i(state_rd_addr_i),
		.rd_en_i({post_history_rd_en_i, threshold_rd_en_i, potential_rd_en_i, bias_rd_en_i}),
		.wr_addr_i(state_wr_addr_i),
		.wr_data_i(state_wr_data_i),
		.wr_en_i({post_history_wr_en_i, threshold_wr_en_i, potential_wr_en_i, bias_wr_en_i}),
		.rd_data_o(state_rd_data_o)
	);

	assign weight_bus.rd_en = weight_rd_en_i;
	assign weight_bus.rd_addr = weight_rd_addr_i;
	assign weight_bus.wr_en = weight_wr_en_i;
	assign weight_bus.wr_addr = weight_wr_addr_i;
	assign weight_bus.wr_data = weight_wr_data_i;

	status_bank #(.ADDR_W(SYNAPSE_ADDR_W), .WORD_W(DATA_W)) u_weight_bank
	(
		.clk_i(clk_i),
		.mem(weight_bus)
	);

	assign weight_rd_data_o = weight_bus.rd_data;

	// every weight read is also queued for the learning side
	weight_prefetch_fifo u_weight_fifo
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.clear_i(start_i),
		.rd_strobe_i(weight_rd_en_i),
		.din_i(weight_bus.rd_data),
		.pop_i(weight_pop_i),
		.head_o(weight_head_o),
		.empty_o(weight_empty_o)
	);

endmodule

// File: source/state_field_pkg.sv
// ----------------------------------------
// encoding of the per-neuron state fields
// that share read port A. the code is the
// low part of the shared read address
// ----------------------------------------

package state_field_pkg;

	localparam int FIELD_SEL_W = 2;

	// also the bit index of each field's enable
	typedef enum logic [FIELD_SEL_W-1:0]
	{
		FIELD_BIAS         = 2'd0,
		FIELD_POTENTIAL    = 2'd1,
		FIELD_THRESHOLD    = 2'd2,
		FIELD_POST_HISTORY = 2'd3
	} state_field_e;

endpackage

// File: source/status_bank.sv
// ----------------------------------------
// one memory array with a registered read
// address and an independent write port.
// read word follows the stored address
// ----------------------------------------

module status_bank
#(
	parameter int ADDR_W = 4,
	parameter int WORD_W = 16
)
(
	input logic clk_i,
	bank_if.owner mem
);

	logic [WORD_W-1:0] words [0:(1 << ADDR_W)-1];
	logic [ADDR_W-1:0] rd_addr_q;

	// address held until the next read enable
	always_ff @(posedge clk_i)
	begin
		if (mem.rd_en)
			rd_addr_q <= mem.rd_addr;
	end

	always_ff @(posedge clk_i)
	begin
		if (mem.wr_en)
			words[mem.wr_addr] <= mem.wr_data;
	end

	// combinational, so a later write to the same word shows up
	assign mem.rd_data = words[rd_addr_q];

endmodule

// File: source/weight_prefetch_fifo.sv
// ----------------------------------------
// single-clock FIFO that queues each weight
// one cycle after its read strobe. clear_i
// empties it, full pushes are dropped
// ----------------------------------------

module weight_prefetch_fifo
(
	input logic clk_i,
	input logic rst_n_i,

	input logic clear_i,
	input logic rd_strobe_i,
	input neuron_geom_pkg::data_t din_i,
	input logic pop_i,

	output neuron_geom_pkg::data_t head_o,
	output logic empty_o
);

	import neuron_geom_pkg::*;

	data_t storage [0:(1 << FIFO_ADDR_W)-1];

	logic [FIFO_ADDR_W-1:0] wr_ptr_q;
	logic [FIFO_ADDR_W-1:0] rd_ptr_q;
	logic [FIFO_ADDR_W:0] count_q;

	logic push_q;
	logic full;
	logic push_ok;
	logic pop_ok;

	// memory word is valid the cycle after the strobe
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			push_q <= 1'b0;
		else
			push_q <= rd_strobe_i;
	end

	// top count bit set only at exactly full
	assign full = count_q[FIFO_ADDR_W];
	assign empty_o = (count_q == '0);

	assign push_ok = push_q && !full;
	assign pop_ok = pop_i && !empty_o;

	always_ff @(posedge clk_i)
	begin
		if (push_ok && !clear_i)
			storage[wr_ptr_q] <= din_i;
	end

	// clear takes priority over a push on the same edge
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else if (clear_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push_ok && !pop_ok)
				count_q <= count_q + 1'b1;
			else if (pop_ok && !push_ok)
				count_q <= count_q - 1'b1;
		end
	end

	assign head_o = storage[rd_ptr_q];

endmodule

// File: tb.f
source/neuron_geom_pkg.sv
source/state_field_pkg.sv
source/bank_if.sv
source/status_bank.sv
source/neuron_state_mem.sv
source/weight_prefetch_fifo.sv
source/neuron_status_mem.sv
verification/tb_neuron_status_mem.sv

// File: verification/status_vectors.txt
# columns: op addr data expect count, all hex except the decimal count
# W/R addr = neuron*4 + field, G/E addr = neuron*16 + axon, repeats step addr and data
# P addr = expected empty flag before the pop, C expect = expected empty flag
C 00 0000 0001 1
# four fields of neuron 5 plus a neighbour
W 14 1234 0000 1
W 15 5678 0000 1
W 16 9abc 0000 1
W 17 00de 0000 1
W 18 aaaa 0000 1
R 14 0000 1234 1
R 15 0000 5678 1
R 16 0000 9abc 1
R 17 0000 00de 1
R 18 0000 aaaa 1
# history keeps only the low byte
W 1b beef 0000 1
R 1b 0000 00ef 1
R 17 0000 00de 1
W 3d 7fff 0000 1
R 3d 0000 7fff 1
# weights around neuron 2 axon 3
G 22 1111 0000 1
G 24 2222 0000 1
G 33 3333 0000 1
G 23 c0de 0000 1
E 23 0000 c0de 1
E 22 0000 1111 1
E 24 0000 2222 1
E 33 0000 3333 1
S 00 0000 0000 1
C 00 0000 0001 1
# queue keeps read order
E 22 0000 1111 1
E 23 0000 c0de 1
E 33 0000 3333 1
C 00 0000 0000 1
P 00 0000 1111 1
P 00 0000 c0de 1
P 00 0000 3333 1
C 00 0000 0001 1
# start with entries queued
E 22 0000 1111 1
E 24 0000 2222 1
S 00 0000 0000 1
C 00 0000 0001 1
P 01 0000 0000 1
E 33 0000 3333 1
P 00 0000 3333 1
# overflow, the 33rd word is dropped
G 40 3000 0000 33
E 40 0000 3000 33
P 00 0000 3000 32
C 00 0000 0001 1
P 01 0000 0000 1

// File: verification/tb_neuron_status_mem.sv
// ----------------------------------------
// testbench for the core status memory.
// runs the operations of the vector file
// and checks every read and queue result
// ----------------------------------------

module tb_neuron_status_mem;

	timeunit 1ns;
	timeprecision 100ps;

	import neuron_geom_pkg::*;
	import state_field_pkg::*;

	localparam string VECTOR_FILE = "verification/status_vectors.txt";
	localparam int CYCLES_PER_OP = 4;
	localparam int SPARE_CYCLES = 50;

	logic clk_i;
	logic rst_n_i;
	logic start_i;

	logic [STATE_RD_ADDR_W-1:0] state_rd_addr_i;
	logic [3:0] state_rd_en;
	data_t state_rd_data_o;
	neuron_addr_t state_wr_addr_i;
	data_t state_wr_data_i;
	logic [3:0] state_wr_en;

	synapse_addr_t weight_rd_addr_i;
	logic weight_rd_en_i;
	data_t weight_rd_data_o;
	synapse_addr_t weight_wr_addr_i;
	logic weight_wr_en_i;
	data_t weight_wr_data_i;

	logic weight_pop_i;
	data_t weight_head_o;
	logic weight_empty_o;

	// one entry per vector line
	logic [7:0] op_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [31:0] exp_q [$];
	int repeat_q [$];

	int error_count;
	int check_count;
	int cycle_count = 0;
	int cycle_limit = SPARE_CYCLES;

	neuron_status_mem DUT
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.state_rd_addr_i(state_rd_addr_i),
		.bias_rd_en_i(state_rd_en[FIELD_BIAS]),
		.potential_rd_en_i(state_rd_en[FIELD_POTENTIAL]),
		.threshold_rd_en_i(state_rd_en[FIELD_THRESHOLD]),
		.post_history_rd_en_i(state_rd_en[FIELD_POST_HISTORY]),
		.state_rd_data_o(state_rd_data_o),
		.state_wr_addr_i(state_wr_addr_i),
		.state_wr_data_i(state_wr_data_i),
		.bias_wr_en_i(state_wr_en[FIELD_BIAS]),
		.potential_wr_en_i(state_wr_en[FIELD_POTENTIAL]),
		.threshold_wr_en_i(state_wr_en[FIELD_THRESHOLD]),
		.post_history_wr_en_i(state_wr_en[FIELD_POST_HISTORY]),
		.weight_rd_addr_i(weight_rd_addr_i),
		.weight_rd_en_i(weight_rd_en_i),
		.weight_rd_data_o(weight_rd_data_o),
		.weight_wr_addr_i(weight_wr_addr_i),
		.weight_wr_en_i(weight_wr_en_i),
		.weight_wr_data_i(weight_wr_data_i),
		.weight_pop_i(weight_pop_i),
		.weight_head_o(weight_head_o),
		.weight_empty_o(weight_empty_o)
	);

	always
	begin
		#5 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("checks: %0d, errors: %0d", check_count, error_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic report_mismatch(input string what, input data_t expected, input data_t actual);
		error_count++;
		$display("Fail %0t: %s expected %h, got %h", $time, what, expected, actual);
	endtask

	task automatic load_vectors();
		int fd;
		int code;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		int n;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
		begin
			error_count++;
			$display("could not open the vector file %s", VECTOR_FILE);
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				// comments and blank lines
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %d", a, d, e, n);
				if (code != 4)
				begin
					error_count++;
					$display("malformed vector line: %s", line);
				end
				else
				begin
					op_q.push_back(line.getc(0));
					addr_q.push_back(a);
					data_q.push_back(d);
					exp_q.push_back(e);
					repeat_q.push_back(n);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_state(input logic [STATE_RD_ADDR_W-1:0] addr, input data_t data);
		@(posedge clk_i);
		state_wr_addr_i <= addr[STATE_RD_ADDR_W-1:FIELD_SEL_W];
		state_wr_data_i <= data;
		state_wr_en <= 4'b0001 << addr[FIELD_SEL_W-1:0];
		@(posedge clk_i);
		state_wr_en <= '0;
	endtask

	task automatic read_state(input logic [STATE_RD_ADDR_W-1:0] addr, input data_t expected);
		@(posedge clk_i);
		state_rd_addr_i <= addr;
		state_rd_en <= 4'b0001 << addr[FIELD_SEL_W-1:0];
		@(posedge clk_i);
		state_rd_en <= '0;
		// word valid until the following edge
		@(negedge clk_i);
		check_count++;
		if (state_rd_data_o !== expected)
			report_mismatch($sformatf("R %h", addr), expected, state_rd_data_o);
	endtask

	task automatic write_weight(input synapse_addr_t addr, input data_t data);
		@(posedge clk_i);
		weight_wr_addr_i <= addr;
		weight_wr_data_i <= data;
		weight_wr_en_i <= 1'b1;
		@(posedge clk_i);
		weight_wr_en_i <= 1'b0;
	endtask

	task automatic read_weight(input synapse_addr_t addr, input data_t expected);
		@(posedge clk_i);
		weight_rd_addr_i <= addr;
		weight_rd_en_i <= 1'b1;
		@(posedge clk_i);
		weight_rd_en_i <= 1'b0;
		@(negedge clk_i);
		check_count++;
		if (weight_rd_data_o !== expected)
			report_mismatch($sformatf("E %h", addr), expected, weight_rd_data_o);
	endtask

	// the previous read is queued on the first edge here
	task automatic pop_head(input logic expect_empty, input data_t expected);
		@(posedge clk_i);
		weight_pop_i <= 1'b1;
		@(negedge clk_i);
		check_count++;
		if (weight_empty_o !== expect_empty)
			report_mismatch("P empty flag", 16'(expect_empty), 16'(weight_empty_o));
		else if (!expect_empty && weight_head_o !== expected)
			report_mismatch("P head", expected, weight_head_o);
		@(posedge clk_i);
		weight_pop_i <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk_i);
		start_i <= 1'b1;
		@(posedge clk_i);
		start_i <= 1'b0;
	endtask

	task automatic check_empty(input logic expect_empty);
		@(posedge clk_i);
		@(negedge clk_i);
		check_count++;
		if (weight_empty_o !== expect_empty)
			report_mismatch("C empty flag", 16'(expect_empty), 16'(weight_empty_o));
	endtask

	// repeated lines step the address and the words by one
	task automatic run_vector(input int idx);
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		for (int k = 0; k < repeat_q[idx]; k++)
		begin
			a = addr_q[idx] + 32'(k);
			d = data_q[idx] + 32'(k);
			e = exp_q[idx] + 32'(k);
			case (op_q[idx])
				"W": write_state(a[STATE_RD_ADDR_W-1:0], d[DATA_W-1:0]);
				"R": read_state(a[STATE_RD_ADDR_W-1:0], e[DATA_W-1:0]);
				"G": write_weight(a[SYNAPSE_ADDR_W-1:0], d[DATA_W-1:0]);
				"E": read_weight(a[SYNAPSE_ADDR_W-1:0], e[DATA_W-1:0]);
				"P": pop_head(addr_q[idx][0], e[DATA_W-1:0]);
				"S": pulse_start();
				"C": check_empty(e[0]);
				default:
				begin
					error_count++;
					$display("unknown operation %c in vector %0d", op_q[idx], idx);
				end
			endcase
		end
	endtask

	initial
	begin
		int total_ops;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		start_i = 1'b0;
		state_rd_addr_i = '0;
		state_rd_en = '0;
		state_wr_addr_i = '0;
		state_wr_data_i = '0;
		state_wr_en = '0;
		weight_rd_addr_i = '0;
		weight_rd_en_i = 1'b0;
		weight_wr_addr_i = '0;
		weight_wr_en_i = 1'b0;
		weight_wr_data_i = '0;
		weight_pop_i = 1'b0;
		error_count = 0;
		check_count = 0;
		total_ops = 0;

		load_vectors();
		foreach (repeat_q[i])
			total_ops += repeat_q[i];
		cycle_limit = CYCLES_PER_OP * total_ops + SPARE_CYCLES;

		repeat (5) @(posedge clk_i);
		rst_n_i <= 1'b1;

		for (int i = 0; i < op_q.size(); i++)
			run_vector(i);

		repeat (2) @(posedge clk_i);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
